// File: src/branch_pkg.sv
package branch_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int INSTR_W = 32;
    localparam int OPC_W   = 7;
    localparam int CNT_W   = 2;

    localparam logic [CNT_W-1:0] CNT_INIT = 2'd1; // weakly not taken.

    // ----------------------------------------
    // opcodes
    // ----------------------------------------
    localparam logic [OPC_W-1:0] OPC_J = 7'b1101111; // jal, J_FORMAT.
    localparam logic [OPC_W-1:0] OPC_B = 7'b1100011; // conditional branches, B_FORMAT.

    // one fetched word, seen as a B-type or a J-type instruction.
    // the immediate fields hold the offset as a word count.
    typedef union packed {
        logic [INSTR_W-1:0] raw;
        struct packed {
            logic             imm12;
            logic [5:0]       imm10_5;
            logic [4:0]       rs2;
            logic [4:0]       rs1;
            logic [2:0]       funct3;
            logic [3:0]       imm4_1;
            logic             imm11;
            logic [OPC_W-1:0] opcode;
        } b_view;
        struct packed {
            logic             imm20;
            logic [9:0]       imm10_1;
            logic             imm11;
            logic [7:0]       imm19_12;
            logic [4:0]       rd;
            logic [OPC_W-1:0] opcode;
        } j_view;
    } instr_word_t;

endpackage

// File: src/fetch_unit.sv
module fetch_unit #(
    parameter int PC_SIZE = 6
) (
    input  logic                           CLK,
    input  logic                           rst,
    input  branch_pkg::instr_word_t        imem_data,
    input  logic                           do_jump,
    input  logic [PC_SIZE-1:0]             predictor_jump_pc,
    output logic [PC_SIZE-1:0]             imem_addr,
    output logic [PC_SIZE-1:0]             fetch_pc,
    output logic [branch_pkg::OPC_W-1:0]   fetch_opcode,
    output logic [PC_SIZE-1:0]             next_consecutive_pc,
    output logic [PC_SIZE-1:0]             jump_pc
);
    import branch_pkg::*;

    logic [PC_SIZE-1:0] pc;
    logic [INSTR_W-1:0] offset;

    // ----------------------------------------
    // program counter
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else if (do_jump) begin
            pc <= predictor_jump_pc; // taken or recovery.
        end else begin
            pc <= next_consecutive_pc;
        end
    end

    assign imem_addr           = pc;
    assign fetch_pc            = pc;
    assign next_consecutive_pc = pc + 1'b1;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    assign fetch_opcode = imem_data.b_view.opcode; // same bits in both views.

    always_comb begin
        if (imem_data.j_view.opcode == OPC_J) begin
            offset = {{(INSTR_W - 20){imem_data.j_view.imm20}},
                      imem_data.j_view.imm20,
                      imem_data.j_view.imm19_12,
                      imem_data.j_view.imm11,
                      imem_data.j_view.imm10_1};
        end else begin
            // B layout, only meaningful for branches.
            offset = {{(INSTR_W - 12){imem_data.b_view.imm12}},
                      imem_data.b_view.imm12,
                      imem_data.b_view.imm11,
                      imem_data.b_view.imm10_5,
                      imem_data.b_view.imm4_1};
        end
    end

    assign jump_pc = pc + offset[PC_SIZE-1:0]; // wraps in the PC space.

endmodule

// File: src/jump_predictor.sv
module jump_predictor #(
    parameter int PC_SIZE = 6
) (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic [branch_pkg::OPC_W-1:0]   fetch_opcode,
    input  logic [PC_SIZE-1:0]             fetch_pc,
    input  logic [PC_SIZE-1:0]             next_consecutive_pc,
    input  logic [PC_SIZE-1:0]             jump_pc,
    input  logic                           resolve_valid,
    input  logic                           should_have_jumped,
    output logic                           do_jump,
    output logic [PC_SIZE-1:0]             predictor_jump_pc,
    output logic                           force_nop
);
    import branch_pkg::*;

    logic [CNT_W-1:0] cnt_table [2**PC_SIZE];
    logic [CNT_W-1:0] rec_cnt;
    logic             predict_taken;

    // last prediction.
    logic               rec_valid;
    logic               rec_taken;
    logic               rec_branch;
    logic [PC_SIZE-1:0] rec_pc;
    logic [PC_SIZE-1:0] rec_recovery_pc;

    // ----------------------------------------
    // prediction
    // ----------------------------------------
    // counter msb set means 2 or 3.
    assign predict_taken = (fetch_opcode == OPC_J) ||
                           ((fetch_opcode == OPC_B) && cnt_table[fetch_pc][CNT_W-1]);

    assign force_nop = rec_valid && resolve_valid && (rec_taken != should_have_jumped);
    assign do_jump   = force_nop || predict_taken;

    always_comb begin
        if (force_nop) begin
            predictor_jump_pc = rec_recovery_pc;
        end else if (predict_taken) begin
            predictor_jump_pc = jump_pc;
        end else begin
            predictor_jump_pc = next_consecutive_pc;
        end
    end

    // ----------------------------------------
    // prediction record
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            rec_valid  <= 1'b0;
            rec_taken  <= 1'b0;
            rec_branch <= 1'b0;
        end else begin
            rec_valid  <= !force_nop; // wrong-path fetch is not recorded.
            rec_taken  <= predict_taken;
            rec_branch <= (fetch_opcode == OPC_B);
        end
    end

    always_ff @(posedge CLK) begin
        rec_pc          <= fetch_pc;
        rec_recovery_pc <= predict_taken ? next_consecutive_pc : jump_pc; // path not taken.
    end

    // ----------------------------------------
    // counter training
    // ----------------------------------------
    assign rec_cnt = cnt_table[rec_pc];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 2**PC_SIZE; i++) begin
                cnt_table[i] <= CNT_INIT;
            end
        end else if (rec_valid && resolve_valid && rec_branch) begin
            if (should_have_jumped && (rec_cnt != '1)) begin
                cnt_table[rec_pc] <= rec_cnt + 1'b1;
            end else if (!should_have_jumped && (rec_cnt != '0)) begin
                cnt_table[rec_pc] <= rec_cnt - 1'b1;
            end
        end
    end

endmodule

// File: src/branch_buffer.sv
module branch_buffer #(
    parameter int PC_SIZE = 6
) (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic [PC_SIZE-1:0]             fetch_pc,
    input  logic [branch_pkg::OPC_W-1:0]   fetch_opcode,
    input  logic                           force_nop,
    output logic                           slot_valid,
    output logic [PC_SIZE-1:0]             slot_pc,
    output logic [branch_pkg::OPC_W-1:0]   slot_opcode
);
    import branch_pkg::*;

    logic [OPC_W-1:0] opcode_q;

    // ----------------------------------------
    // fetch to execute slot
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= !force_nop; // squash the wrong-path word.
        end
    end

    always_ff @(posedge CLK) begin
        slot_pc  <= fetch_pc;
        opcode_q <= fetch_opcode;
    end

    assign slot_opcode = opcode_q;

endmodule

// File: src/branch_resolver.sv
module branch_resolver #(
    parameter int PC_SIZE = 6
) (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic                           slot_valid,
    input  logic [PC_SIZE-1:0]             slot_pc,
    input  logic [branch_pkg::OPC_W-1:0]   slot_opcode,
    input  logic                           branch_taken,
    input  logic                           force_nop,
    output logic                           resolve_valid,
    output logic                           should_have_jumped,
    output logic                           retire_valid,
    output logic [PC_SIZE-1:0]             retire_pc,
    output logic [15:0]                    mispredict_count
);
    import branch_pkg::*;

    logic actual_taken;

    // ----------------------------------------
    // actual outcome
    // ----------------------------------------
    always_comb begin
        case (slot_opcode)
            OPC_J:   actual_taken = 1'b1;
            OPC_B:   actual_taken = branch_taken; // execute compare.
            default: actual_taken = 1'b0;
        endcase
    end

    assign resolve_valid      = slot_valid;
    assign should_have_jumped = slot_valid && actual_taken;

    // retire in the resolve cycle.
    assign retire_valid = slot_valid;
    assign retire_pc    = slot_pc;

    // ----------------------------------------
    // misprediction count
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            mispredict_count <= '0;
        end else if (force_nop) begin
            mispredict_count <= mispredict_count + 1'b1;
        end
    end

endmodule

// File: src/branch_front_end.sv
module branch_front_end #(
    parameter int PC_SIZE = 6
) (
    input  logic                      CLK,
    input  logic                      rst,
    input  branch_pkg::instr_word_t   imem_data,
    input  logic                      branch_taken,
    output logic [PC_SIZE-1:0]        imem_addr,
    output logic                      retire_valid,
    output logic [PC_SIZE-1:0]        retire_pc,
    output logic                      mispredict,
    output logic [15:0]               mispredict_count
);
    import branch_pkg::*;

    // fetch side.
    logic [PC_SIZE-1:0] fetch_pc;
    logic [OPC_W-1:0]   fetch_opcode;
    logic [PC_SIZE-1:0] next_consecutive_pc;
    logic [PC_SIZE-1:0] jump_pc;

    // predictor decisions.
    logic               do_jump;
    logic [PC_SIZE-1:0] predictor_jump_pc;
    logic               force_nop;

    // execute side.
    logic               slot_valid;
    logic [PC_SIZE-1:0] slot_pc;
    logic [OPC_W-1:0]   slot_opcode;
    logic               resolve_valid;
    logic               should_have_jumped;

    fetch_unit #(.PC_SIZE(PC_SIZE)) fetch_unit_i (
        .CLK, .rst, .imem_data, .do_jump, .predictor_jump_pc,
        .imem_addr, .fetch_pc, .fetch_opcode, .next_consecutive_pc, .jump_pc
    );

    jump_predictor #(.PC_SIZE(PC_SIZE)) jump_predictor_i (
        .CLK, .rst, .fetch_opcode, .fetch_pc, .next_consecutive_pc, .jump_pc,
        .resolve_valid, .should_have_jumped,
        .do_jump, .predictor_jump_pc, .force_nop
    );

    branch_buffer #(.PC_SIZE(PC_SIZE)) branch_buffer_i (
        .CLK, .rst, .fetch_pc, .fetch_opcode, .force_nop,
        .slot_valid, .slot_pc, .slot_opcode
    );

    branch_resolver #(.PC_SIZE(PC_SIZE)) branch_resolver_i (
        .CLK, .rst, .slot_valid, .slot_pc, .slot_opcode, .branch_taken, .force_nop,
        .resolve_valid, .should_have_jumped, .retire_valid, .retire_pc, .mispredict_count
    );

    assign mispredict = force_nop; // one cycle per wrong guess.

endmodule

// File: bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ----------------------------------------
// program
// ----------------------------------------
localparam int PROG_DEPTH = 2**PC_SIZE;

localparam logic [31:0] JAL_FWD3  = 32'h0060006F; // pc 2, jal +3 to 5.
localparam logic [31:0] BEQ_BACK2 = 32'hFE000EE3; // pc 7, beq -2 to 5.
localparam logic [31:0] JAL_BACK3 = 32'hFFBFF06F; // pc 8, jal -3 to 5.

// unused words are addi x0, x0, addr.
function automatic logic [31:0] fill_word(input int addr);
    return 32'h00000013 | (32'(addr) << 20);
endfunction

// targets as written in the program above.
function automatic logic [PC_SIZE-1:0] jump_target(input logic [PC_SIZE-1:0] addr);
    case (addr)
        2, 7, 8: return 6'd5;
        default: return addr + 1'b1; // not a jump.
    endcase
endfunction

task automatic load_program();
    for (int a = 0; a < PROG_DEPTH; a++) begin
        mem[a] = fill_word(a);
    end
    mem[2] = JAL_FWD3;
    mem[7] = BEQ_BACK2;
    mem[8] = JAL_BACK3;
endtask

// ----------------------------------------
// per-cycle table
// ----------------------------------------
typedef struct packed {
    logic               taken;
    logic               valid;
    logic [PC_SIZE-1:0] pc;
    logic               mis;
} row_t;

localparam int NUM_ROWS = 26;

row_t rows [NUM_ROWS];

// branch_taken, retire_valid, retire_pc, mispredict; row 0 is the first retire.
task automatic load_rows();
    rows[0]  = '{1'b0, 1'b1, 6'd0, 1'b0};
    rows[1]  = '{1'b0, 1'b1, 6'd1, 1'b0};
    rows[2]  = '{1'b0, 1'b1, 6'd2, 1'b0}; // jal, predicted taken.
    rows[3]  = '{1'b0, 1'b1, 6'd5, 1'b0};
    rows[4]  = '{1'b0, 1'b1, 6'd6, 1'b0};
    rows[5]  = '{1'b1, 1'b1, 6'd7, 1'b1}; // counter 1, predicted not taken.
    rows[6]  = '{1'b0, 1'b0, 6'd8, 1'b0}; // squashed.
    rows[7]  = '{1'b0, 1'b1, 6'd5, 1'b0};
    rows[8]  = '{1'b0, 1'b1, 6'd6, 1'b0};
    rows[9]  = '{1'b1, 1'b1, 6'd7, 1'b0}; // counter 2, now taken.
    rows[10] = '{1'b0, 1'b1, 6'd5, 1'b0};
    rows[11] = '{1'b0, 1'b1, 6'd6, 1'b0};
    rows[12] = '{1'b1, 1'b1, 6'd7, 1'b0};
    rows[13] = '{1'b0, 1'b1, 6'd5, 1'b0};
    rows[14] = '{1'b0, 1'b1, 6'd6, 1'b0};
    rows[15] = '{1'b0, 1'b1, 6'd7, 1'b1}; // loop exit.
    rows[16] = '{1'b0, 1'b0, 6'd5, 1'b0};
    rows[17] = '{1'b0, 1'b1, 6'd8, 1'b0};
    rows[18] = '{1'b0, 1'b1, 6'd5, 1'b0};
    rows[19] = '{1'b0, 1'b1, 6'd6, 1'b0};
    rows[20] = '{1'b0, 1'b1, 6'd7, 1'b1}; // counter 2, still taken.
    rows[21] = '{1'b0, 1'b0, 6'd5, 1'b0};
    rows[22] = '{1'b0, 1'b1, 6'd8, 1'b0};
    rows[23] = '{1'b0, 1'b1, 6'd5, 1'b0};
    rows[24] = '{1'b0, 1'b1, 6'd6, 1'b0};
    rows[25] = '{1'b0, 1'b1, 6'd7, 1'b0}; // counter 1, agrees.
endtask

`endif

// File: bench/tb_branch_front_end.sv
module tb_branch_front_end;
    import branch_pkg::*;

    localparam int PC_SIZE        = 6;
    localparam int RETIRE_TIMEOUT = 20;
    localparam int RANDOM_CYCLES  = 200;

    logic               CLK;
    logic               rst;
    instr_word_t        imem_data;
    logic               branch_taken;
    logic [PC_SIZE-1:0] imem_addr;
    logic               retire_valid;
    logic [PC_SIZE-1:0] retire_pc;
    logic               mispredict;
    logic [15:0]        mispredict_count;

    logic [INSTR_W-1:0] mem [2**PC_SIZE];
    int                 value_errors;
    int                 timeouts;
    logic [31:0]        rng_state;

    // reference model.
    logic [PC_SIZE-1:0] m_pc;
    logic               m_slot_valid; // record is squashed along with the slot.
    logic [PC_SIZE-1:0] m_slot_pc;
    logic [OPC_W-1:0]   m_slot_op;
    logic               m_rec_taken;
    logic [PC_SIZE-1:0] m_rec_alt;
    logic [1:0]         m_cnt [2**PC_SIZE];
    logic               m_mis;
    logic               m_ret_valid;
    logic [PC_SIZE-1:0] m_ret_pc;
    int                 m_tally;

    `include "tb_program.svh"

    branch_front_end #(.PC_SIZE(PC_SIZE)) branch_front_end_i (
        .CLK, .rst, .imem_data, .branch_taken,
        .imem_addr, .retire_valid, .retire_pc, .mispredict, .mispredict_count
    );

    assign imem_data = mem[imem_addr]; // combinational read.

    always #5 CLK = ~CLK;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
            value_errors++;
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic model_reset();
        m_pc         = '0;
        m_slot_valid = 1'b0;
        m_slot_pc    = '0;
        m_slot_op    = '0;
        m_rec_taken  = 1'b0;
        m_rec_alt    = '0;
        m_tally      = 0;
        for (int i = 0; i < 2**PC_SIZE; i++) begin
            m_cnt[i] = 2'd1;
        end
    endtask

    // outputs of the current cycle, then state for the next one.
    task automatic model_step(input logic taken);
        logic [OPC_W-1:0]   op;
        logic               pred;
        logic               actual;
        logic [PC_SIZE-1:0] target;
        op     = mem[m_pc][OPC_W-1:0];
        target = jump_target(m_pc);
        pred   = (op == OPC_J) || ((op == OPC_B) && (m_cnt[m_pc] >= 2));
        actual = (m_slot_op == OPC_J) || ((m_slot_op == OPC_B) && taken);
        m_mis       = m_slot_valid && (m_rec_taken != actual);
        m_ret_valid = m_slot_valid;
        m_ret_pc    = m_slot_pc;
        if (m_mis) begin
            m_tally++;
        end
        if (m_slot_valid && (m_slot_op == OPC_B)) begin
            if (actual && (m_cnt[m_slot_pc] != 2'd3)) begin
                m_cnt[m_slot_pc]++;
            end else if (!actual && (m_cnt[m_slot_pc] != 2'd0)) begin
                m_cnt[m_slot_pc]--;
            end
        end
        m_slot_valid = !m_mis;
        m_slot_pc    = m_pc;
        m_slot_op    = op;
        if (m_mis) begin
            m_pc = m_rec_alt;
        end else begin
            m_pc = pred ? target : m_pc + 1'b1;
        end
        m_rec_taken = pred;
        m_rec_alt   = pred ? m_slot_pc + 1'b1 : target; // path not chosen.
    endtask

    // drive just after the edge, sample at the falling edge.
    task automatic next_cycle(input logic taken);
        @(posedge CLK);
        #1 branch_taken = taken;
        #4;
        model_step(taken);
    endtask

    task automatic wait_first_retire(output logic ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        while (retire_valid !== 1'b1) begin
            if (waited == RETIRE_TIMEOUT) begin
                $display("timed out waiting for the first retired instruction");
                timeouts++;
                ok = 1'b0;
                break;
            end
            next_cycle(rows[0].taken);
            waited++;
        end
    endtask

    task automatic apply_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i != 0) begin
                next_cycle(rows[i].taken);
            end
            compare("retire_valid", retire_valid, rows[i].valid);
            if (rows[i].valid) begin
                compare("retire_pc", retire_pc, rows[i].pc);
            end
            compare("mispredict", mispredict, rows[i].mis);
        end
    endtask

    // random outcomes on the beq at pc 7.
    task automatic random_phase();
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rng_state = xorshift32(rng_state);
            next_cycle(rng_state[16]);
            compare("mispredict", mispredict, m_mis);
            compare("retire_valid", retire_valid, m_ret_valid);
            if (m_ret_valid) begin
                compare("retire_pc", retire_pc, m_ret_pc);
            end
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic ok;
        CLK          = 1'b0;
        rst          = 1'b1;
        branch_taken = 1'b0;
        value_errors = 0;
        timeouts     = 0;
        rng_state    = 32'd86685;
        load_program();
        load_rows();
        model_reset();
        repeat (5) @(posedge CLK);
        #1 rst = 1'b0;
        #4;
        compare("imem_addr", imem_addr, 0); // first cycle out of reset.
        compare("retire_valid", retire_valid, 0);
        compare("mispredict", mispredict, 0);
        model_step(1'b0);
        wait_first_retire(ok);
        if (ok) begin
            apply_table();
            random_phase();
            @(posedge CLK);
            #1;
            compare("mispredict_count", mispredict_count, m_tally);
        end
        $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
        if ((value_errors == 0) && (timeouts == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+bench
src/branch_pkg.sv
src/fetch_unit.sv
src/jump_predictor.sv
src/branch_buffer.sv
src/branch_resolver.sv
src/branch_front_end.sv
bench/tb_branch_front_end.sv
